// ==== design/wordGamePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word game package: letter and word sizes, game state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wordGamePkg;

    // one ASCII character
    localparam int LETTER_W = 8;

    // letters per secret word
    localparam int WORD_LEN = 5;

    // game FSM states
    // CMP0..CMP4 walk the word one position per clock
    typedef enum logic [2:0] {
        SETUP     = 3'd0,
        CMP0      = 3'd1,
        CMP1      = 3'd2,
        CMP2      = 3'd3,
        CMP3      = 3'd4,
        CMP4      = 3'd5,
        SCORE     = 3'd6,
        WAITGUESS = 3'd7
    } gameState_t;

endpackage

// ==== design/wordLoader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wordLoader: shift register collecting the host's secret word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wordLoader
    import wordGamePkg::*;
(
    input  logic                         clk,
    input  logic                         nRst,
    input  logic                         loadEn,
    input  logic                         clear,
    input  logic [LETTER_W-1:0]          letterIn,
    input  logic                         letterStrobe,
    output logic [LETTER_W*WORD_LEN-1:0] word,
    output logic                         wordFull
);

    localparam int CNT_W = $clog2(WORD_LEN + 1);

    logic [CNT_W-1:0] letterCnt;
    logic             accept;

    assign wordFull = (letterCnt == CNT_W'(WORD_LEN));

    // extra strobes after the fifth letter are ignored
    assign accept = letterStrobe && loadEn && !wordFull;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            letterCnt <= '0;
            word      <= '0;
        end else if (clear) begin
            letterCnt <= '0;
            word      <= '0;
        end else if (accept) begin
            letterCnt <= letterCnt + CNT_W'(1);
            // shift left so the first letter lands in the top slot
            word      <= {word[LETTER_W*(WORD_LEN-1)-1:0], letterIn};
        end
    end

endmodule

// ==== design/guessDetect.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// guessDetect: samples the guess level and flags each change
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module guessDetect
    import wordGamePkg::*;
(
    input  logic                clk,
    input  logic                nRst,
    input  logic [LETTER_W-1:0] guess,
    output logic [LETTER_W-1:0] guessLetter,
    output logic                newGuess
);

    // guessLetter doubles as the copy of the last sample,
    // so a nonzero guess right after reset counts as a change
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            guessLetter <= '0;
            newGuess    <= 1'b0;
        end else begin
            guessLetter <= guess;
            newGuess    <= (guess != guessLetter);
        end
    end

endmodule

// ==== design/gameLogic.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gameLogic: round FSM, per-position compare, scoring, win/lose
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module gameLogic
    import wordGamePkg::*;
#(
    parameter int MAX_MISTAKES = 6
) (
    input  logic                         clk,
    input  logic                         nRst,
    input  logic [LETTER_W*WORD_LEN-1:0] word,
    input  logic                         wordFull,
    input  logic                         confirm,
    input  logic [LETTER_W-1:0]          guessLetter,
    input  logic                         newGuess,
    output logic                         loadEn,
    output logic                         newRound,
    output logic                         ready,
    output logic                         busy,
    output logic [WORD_LEN-1:0]          found,
    output logic [2:0]                   correctCount,
    output logic [2:0]                   mistakeCount,
    output logic                         mistake,
    output logic                         win,
    output logic                         lose
);

    gameState_t          state;
    gameState_t          nextState;
    logic                gameOver;
    logic [LETTER_W-1:0] curGuess;
    logic [LETTER_W-1:0] letters [WORD_LEN];
    logic [2:0]          cmpPos;
    logic                isCmp;
    logic                cmpHit;
    logic [WORD_LEN-1:0] newMask;
    logic [WORD_LEN-1:0] foundNext;
    logic [2:0]          newHits;

    assign gameOver = win | lose;

    assign loadEn = (state == SETUP);
    assign ready  = (state == SETUP) || (state == WAITGUESS);
    assign busy   = !ready;

    // split the word, position 0 is the top letter
    always_comb begin
        for (int i = 0; i < WORD_LEN; i++) begin
            letters[i] = word[(WORD_LEN-1-i)*LETTER_W +: LETTER_W];
        end
    end

    // which position the current compare state looks at
    always_comb begin
        isCmp  = 1'b1;
        cmpPos = 3'd0;
        case (state)
            CMP0:    cmpPos = 3'd0;
            CMP1:    cmpPos = 3'd1;
            CMP2:    cmpPos = 3'd2;
            CMP3:    cmpPos = 3'd3;
            CMP4:    cmpPos = 3'd4;
            default: isCmp  = 1'b0;
        endcase
    end

    // already found positions never count again
    assign cmpHit = isCmp && (curGuess == letters[cmpPos]) && !found[cmpPos];

    assign foundNext = found | newMask;

    always_comb begin
        newHits = 3'd0;
        for (int i = 0; i < WORD_LEN; i++) begin
            newHits = newHits + 3'(newMask[i]);
        end
    end

    always_comb begin
        nextState = state;
        newRound  = 1'b0;
        case (state)
            SETUP: begin
                if (confirm && wordFull) begin
                    nextState = WAITGUESS;
                end
            end
            WAITGUESS: begin
                if (gameOver) begin
                    // guesses are dropped once the game is decided
                    if (confirm) begin
                        newRound  = 1'b1;
                        nextState = SETUP;
                    end
                end else if (newGuess) begin
                    nextState = CMP0;
                end
            end
            CMP0:    nextState = CMP1;
            CMP1:    nextState = CMP2;
            CMP2:    nextState = CMP3;
            CMP3:    nextState = CMP4;
            CMP4:    nextState = SCORE;
            SCORE:   nextState = WAITGUESS;
            default: nextState = SETUP;
        endcase
    end

    // guess held stable for the whole compare pass
    always_ff @(posedge clk) begin
        if (state == WAITGUESS && newGuess && !gameOver) begin
            curGuess <= guessLetter;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state        <= SETUP;
            newMask      <= '0;
            found        <= '0;
            correctCount <= 3'd0;
            mistakeCount <= 3'd0;
            mistake      <= 1'b0;
            win          <= 1'b0;
            lose         <= 1'b0;
        end else begin
            state   <= nextState;
            mistake <= 1'b0;

            if (state == WAITGUESS) begin
                newMask <= '0;
            end
            if (cmpHit) begin
                newMask[cmpPos] <= 1'b1;
            end

            if (state == SCORE) begin
                if (newHits != 3'd0) begin
                    found        <= foundNext;
                    correctCount <= correctCount + newHits;
                    win          <= &foundNext;
                end else begin
                    // nothing new found, count a mistake
                    mistakeCount <= mistakeCount + 3'd1;
                    mistake      <= 1'b1;
                    lose         <= (int'(mistakeCount) + 1 >= MAX_MISTAKES);
                end
            end

            if (newRound) begin
                found        <= '0;
                correctCount <= 3'd0;
                mistakeCount <= 3'd0;
                win          <= 1'b0;
                lose         <= 1'b0;
            end
        end
    end

endmodule

// ==== design/statusDisplay.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// statusDisplay: win/lose lights, mistake flash, mistake digit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module statusDisplay #(
    parameter int FLASH_CYCLES = 8
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       mistake,
    input  logic [2:0] mistakeCount,
    input  logic       win,
    input  logic       lose,
    output logic       green,
    output logic       red,
    output logic [6:0] segMistakes
);

    localparam int CNT_W = $clog2(FLASH_CYCLES + 1);

    logic [CNT_W-1:0] flashCnt;
    logic [6:0]       segNext;

    // segments gfedcba, active high
    always_comb begin
        case (mistakeCount)
            3'd0: segNext = 7'h3F;
            3'd1: segNext = 7'h06;
            3'd2: segNext = 7'h5B;
            3'd3: segNext = 7'h4F;
            3'd4: segNext = 7'h66;
            3'd5: segNext = 7'h6D;
            3'd6: segNext = 7'h7D;
            3'd7: segNext = 7'h07;
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            flashCnt    <= '0;
            green       <= 1'b0;
            red         <= 1'b0;
            segMistakes <= 7'h3F;
        end else begin
            // the mistake cycle itself is the first flash cycle
            if (mistake) begin
                flashCnt <= CNT_W'(FLASH_CYCLES - 1);
            end else if (flashCnt != '0) begin
                flashCnt <= flashCnt - CNT_W'(1);
            end
            green       <= win;
            red         <= lose || mistake || (flashCnt != '0);
            segMistakes <= segNext;
        end
    end

endmodule

// ==== design/wordGame.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wordGame: top level of the five-letter guessing game
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wordGame
    import wordGamePkg::*;
#(
    parameter int MAX_MISTAKES = 6,
    parameter int FLASH_CYCLES = 8
) (
    input  logic                clk,
    input  logic                nRst,
    input  logic [LETTER_W-1:0] letterIn,
    input  logic                letterStrobe,
    input  logic                confirm,
    input  logic [LETTER_W-1:0] guess,
    output logic                ready,
    output logic                busy,
    output logic [WORD_LEN-1:0] found,
    output logic [2:0]          correctCount,
    output logic [2:0]          mistakeCount,
    output logic                mistake,
    output logic                win,
    output logic                lose,
    output logic                green,
    output logic                red,
    output logic [6:0]          segMistakes
);

    logic [LETTER_W*WORD_LEN-1:0] word;
    logic                         wordFull;
    logic                         loadEn;
    logic                         newRound;
    logic [LETTER_W-1:0]          guessLetter;
    logic                         newGuess;

    // host side, cleared at the start of each round
    wordLoader wordLoader_i (
        .clk          (clk),
        .nRst         (nRst),
        .loadEn       (loadEn),
        .clear        (newRound),
        .letterIn     (letterIn),
        .letterStrobe (letterStrobe),
        .word         (word),
        .wordFull     (wordFull)
    );

    guessDetect guessDetect_i (
        .clk         (clk),
        .nRst        (nRst),
        .guess       (guess),
        .guessLetter (guessLetter),
        .newGuess    (newGuess)
    );

    gameLogic #(
        .MAX_MISTAKES (MAX_MISTAKES)
    ) gameLogic_i (
        .clk          (clk),
        .nRst         (nRst),
        .word         (word),
        .wordFull     (wordFull),
        .confirm      (confirm),
        .guessLetter  (guessLetter),
        .newGuess     (newGuess),
        .loadEn       (loadEn),
        .newRound     (newRound),
        .ready        (ready),
        .busy         (busy),
        .found        (found),
        .correctCount (correctCount),
        .mistakeCount (mistakeCount),
        .mistake      (mistake),
        .win          (win),
        .lose         (lose)
    );

    statusDisplay #(
        .FLASH_CYCLES (FLASH_CYCLES)
    ) statusDisplay_i (
        .clk          (clk),
        .nRst         (nRst),
        .mistake      (mistake),
        .mistakeCount (mistakeCount),
        .win          (win),
        .lose         (lose),
        .green        (green),
        .red          (red),
        .segMistakes  (segMistakes)
    );

endmodule

// ==== verif/wordGame_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the game FSM outputs, bound into gameLogic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wordGameSva #(
    parameter int MAX_MISTAKES = 6
) (
    input logic       clk,
    input logic       nRst,
    input logic       ready,
    input logic       busy,
    input logic       mistake,
    input logic       win,
    input logic       lose,
    input logic [2:0] mistakeCount
);

    // read by the testbench at the end of the run
    int failCount = 0;

    // five compare cycles plus the score cycle, then back to ready
    busySpan: assert property (@(posedge clk) disable iff (!nRst)
            $rose(busy) |-> ##1 busy ##1 busy ##1 busy ##1 busy ##1 busy ##1 ready)
        else begin
            failCount++;
            $error("busy did not stay high for exactly six cycles per guess");
        end

    // one mistake per scored guess
    mistakePulse: assert property (@(posedge clk) disable iff (!nRst) mistake |=> !mistake)
        else begin
            failCount++;
            $error("mistake held high for more than one cycle");
        end

    winLose: assert property (@(posedge clk) disable iff (!nRst) !(win && lose))
        else begin
            failCount++;
            $error("win and lose are high together");
        end

    mistakeLimit: assert property (@(posedge clk) disable iff (!nRst)
            int'(mistakeCount) <= MAX_MISTAKES)
        else begin
            failCount++;
            $error("mistake count went past its limit");
        end

endmodule

bind gameLogic wordGameSva #(
    .MAX_MISTAKES (MAX_MISTAKES)
) wordGameSva_i (
    .clk          (clk),
    .nRst         (nRst),
    .ready        (ready),
    .busy         (busy),
    .mistake      (mistake),
    .win          (win),
    .lose         (lose),
    .mistakeCount (mistakeCount)
);

// ==== verif/tbWordGame.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word game testbench with stimulus, reference model and checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tbWordGame
    import wordGamePkg::*;
();

    localparam int MAX_MISTAKES = 6;
    localparam int FLASH_CYCLES = 8;
    // digits on segments gfedcba
    localparam logic [6:0] SEG_DIGITS [8] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
                                               7'h7D, 7'h07};

    logic clk, nRst, letterStrobe, confirm;
    logic [LETTER_W-1:0] letterIn, guess;
    logic ready, busy, mistake, win, lose, green, red;
    logic [WORD_LEN-1:0] found;
    logic [2:0] correctCount, mistakeCount;
    logic [6:0] segMistakes;

    // reference model state
    logic [LETTER_W*WORD_LEN-1:0] expWord;
    logic [WORD_LEN-1:0] expFound;
    int expCorrect, expMistakes, loaded, checks, errors, timeouts;
    bit expWin, expLose, lastMiss, started;
    event checkEv;

    wordGame wordGame_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // new found mask, number of new matches and mistake flag for one letter
    function automatic void scoreGuess(input logic [LETTER_W*WORD_LEN-1:0] w,
            input logic [WORD_LEN-1:0] f, input logic [LETTER_W-1:0] l,
            output logic [WORD_LEN-1:0] nf, output int hits, output bit miss);
        nf = f;
        hits = 0;
        for (int i = 0; i < WORD_LEN; i++) begin
            if (w[(WORD_LEN-1-i)*LETTER_W +: LETTER_W] == l && !f[i]) begin
                nf[i] = 1'b1;
                hits++;
            end
        end
        miss = (hits == 0);
    endfunction

    function automatic bit inWord(input logic [LETTER_W-1:0] l);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < WORD_LEN; i++) begin
            if (expWord[(WORD_LEN-1-i)*LETTER_W +: LETTER_W] == l) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // a letter that misses and still changes the guess level
    function automatic logic [LETTER_W-1:0] wrongLetter();
        logic [LETTER_W-1:0] l;
        do begin
            l = 8'h41 + 8'($urandom_range(25));
        end while (inWord(l) || l == guess);
        return l;
    endfunction

    task automatic compareValue(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("ERROR %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    initial begin
        forever begin
            @(checkEv);
            compareValue("ready", int'(ready), 1);
            compareValue("busy", int'(busy), 0);
            compareValue("mistake", int'(mistake), 0);
            compareValue("found", int'(found), int'(expFound));
            compareValue("correctCount", int'(correctCount), expCorrect);
            compareValue("mistakeCount", int'(mistakeCount), expMistakes);
            compareValue("win", int'(win), int'(expWin));
            compareValue("lose", int'(lose), int'(expLose));
            compareValue("green", int'(green), int'(expWin));
            compareValue("red", int'(red), int'(expLose || lastMiss));
            compareValue("segMistakes", int'(segMistakes), int'(SEG_DIGITS[3'(expMistakes)]));
        end
    end

    task automatic requestCheck();
        -> checkEv;
        nextCycle();
    endtask

    task automatic clearModel();
        expWord = '0;
        expFound = '0;
        expCorrect = 0;
        expMistakes = 0;
        loaded = 0;
        expWin = 1'b0;
        expLose = 1'b0;
        lastMiss = 1'b0;
        started = 1'b0;
    endtask

    task automatic strobeLetter(input logic [LETTER_W-1:0] l);
        letterIn = l;
        letterStrobe = 1'b1;
        nextCycle();
        letterStrobe = 1'b0;
        if (!started && loaded < WORD_LEN) begin
            expWord = {expWord[LETTER_W*(WORD_LEN-1)-1:0], l};
            loaded++;
        end
    endtask

    task automatic loadRandomWord();
        for (int i = 0; i < WORD_LEN; i++) begin
            strobeLetter(8'h41 + 8'($urandom_range(25)));
        end
    endtask

    // starts a game on a full word, or a new round after a finished game
    task automatic pressConfirm();
        confirm = 1'b1;
        nextCycle();
        confirm = 1'b0;
        if (expWin || expLose) begin
            clearModel();
        end else if (loaded == WORD_LEN) begin
            started = 1'b1;
        end
        nextCycle();
        requestCheck();
    endtask

    task automatic applyGuess(input logic [LETTER_W-1:0] l);
        logic [WORD_LEN-1:0] nf;
        int hits;
        bit miss;
        int waitCnt;
        guess = l;
        if (started && !expWin && !expLose) begin
            scoreGuess(expWord, expFound, l, nf, hits, miss);
            if (miss) begin
                expMistakes++;
                expLose = (expMistakes >= MAX_MISTAKES);
            end else begin
                expFound = nf;
                expCorrect += hits;
                expWin = &nf;
            end
            lastMiss = miss;
            waitCnt = 0;
            while (!busy && waitCnt < 10) begin
                nextCycle();
                waitCnt++;
            end
            if (!busy) begin
                timeouts++;
                $display("timeout: the game never went busy after guess %c", l);
            end
            waitCnt = 0;
            while (!ready && waitCnt < 20) begin
                nextCycle();
                waitCnt++;
            end
            if (!ready) begin
                timeouts++;
                $display("timeout: the game never came back to ready after guess %c", l);
            end
            // mistake pulses in the first ready cycle after the score
            compareValue("mistake", int'(mistake), int'(miss));
            // display outputs trail the score by one cycle
            nextCycle();
        end else begin
            // no game running and the guess is dropped
            lastMiss = 1'b0;
            for (int i = 0; i < 10; i++) begin
                nextCycle();
                compareValue("busy", int'(busy), 0);
                compareValue("red", int'(red), int'(expLose));
            end
        end
        requestCheck();
        // flash holds for its full length when the game goes on
        if (lastMiss && !expLose) begin
            for (int i = 1; i < FLASH_CYCLES; i++) begin
                compareValue("red", int'(red), 1);
                nextCycle();
            end
            compareValue("red", int'(red), 0);
        end
    endtask

    initial begin
        void'($urandom(92));
        nRst = 1'b0;
        letterIn = '0;
        letterStrobe = 1'b0;
        confirm = 1'b0;
        guess = '0;
        clearModel();
        repeat (10) @(posedge clk);
        #1;
        nRst = 1'b1;
        nextCycle();
        requestCheck();

        // confirm on a partial word keeps the game in setup
        strobeLetter("L");
        strobeLetter("E");
        strobeLetter("V");
        pressConfirm();
        applyGuess("Q");
        strobeLetter("E");
        strobeLetter("L");
        pressConfirm();

        // double letter, a miss, a repeated found letter, then the win
        applyGuess("E");
        applyGuess("X");
        applyGuess("E");
        applyGuess("L");
        applyGuess("V");
        applyGuess("Z");
        applyGuess("A");

        // new round lost on misses with one dropped guess after the loss
        pressConfirm();
        loadRandomWord();
        pressConfirm();
        repeat (MAX_MISTAKES + 1) applyGuess(wrongLetter());

        // fresh random word won after one miss
        pressConfirm();
        loadRandomWord();
        pressConfirm();
        applyGuess(wrongLetter());
        for (int i = 0; i < WORD_LEN; i++) begin
            if (!expFound[i]) begin
                applyGuess(expWord[(WORD_LEN-1-i)*LETTER_W +: LETTER_W]);
            end
        end
        applyGuess(wrongLetter());

        nextCycle();
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, wordGame_i.gameLogic_i.wordGameSva_i.failCount);
        if (errors == 0 && timeouts == 0 &&
                wordGame_i.gameLogic_i.wordGameSva_i.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== wordGame.f ====
design/wordGamePkg.sv
design/wordLoader.sv
design/guessDetect.sv
design/gameLogic.sv
design/statusDisplay.sv
design/wordGame.sv
verif/wordGame_sva.sv
verif/tbWordGame.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --assert -f wordGame.f --top-module tbWordGame -o simWordGame &&
{ ./obj_dir/simWordGame +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
